//--- src/soc_pkg.sv
package soc_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 2;

  // Request opcodes
  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  // Default address map
  localparam logic [ADDR_WIDTH-1:0] SRAM_START = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] SRAM_END   = 32'h0000_0FFF;
  localparam logic [ADDR_WIDTH-1:0] GPIO_START = 32'h1A10_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_END   = 32'h1A10_0FFF;

  // GPIO register offsets within the window
  localparam logic [ADDR_WIDTH-1:0] GPIO_OUT_OFS = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_DIR_OFS = 32'h0000_0004;
  localparam logic [ADDR_WIDTH-1:0] GPIO_IN_OFS  = 32'h0000_0008;

  // Credit counts, equal to the FIFO depths by default
  localparam int REQ_CREDITS = 4;
  localparam int RSP_CREDITS = 4;

endpackage

//--- src/req_ingress.sv
`timescale 1ns/1ps

module req_ingress #(
  parameter int REQ_DEPTH = soc_pkg::REQ_CREDITS
) (
  input  logic                           clk,
  input  logic                           rst_n_i,

  input  logic                           req_valid_i,
  input  logic                           req_op_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] req_addr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] req_wdata_i,
  input  logic [soc_pkg::ID_WIDTH-1:0]   req_id_i,
  input  logic                           pop_i,

  output logic                           head_valid_o,
  output logic                           head_op_o,
  output logic [soc_pkg::ADDR_WIDTH-1:0] head_addr_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] head_wdata_o,
  output logic [soc_pkg::ID_WIDTH-1:0]   head_id_o,
  output logic                           req_credit_o
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  logic                           op_mem    [REQ_DEPTH];
  logic [soc_pkg::ADDR_WIDTH-1:0] addr_mem  [REQ_DEPTH];
  logic [soc_pkg::DATA_WIDTH-1:0] wdata_mem [REQ_DEPTH];
  logic [soc_pkg::ID_WIDTH-1:0]   id_mem    [REQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // A request arriving while full means the host broke the credit rule
  assign push = req_valid_i && (count != CNT_W'(REQ_DEPTH));
  assign pop  = pop_i && (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr]    <= req_op_i;
      addr_mem[wr_ptr]  <= req_addr_i;
      wdata_mem[wr_ptr] <= req_wdata_i;
      id_mem[wr_ptr]    <= req_id_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      req_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count        <= count + CNT_W'(push) - CNT_W'(pop);
      // One credit back to the host per entry taken by the router
      req_credit_o <= pop;
    end
  end

  assign head_valid_o = (count != '0);
  assign head_op_o    = op_mem[rd_ptr];
  assign head_addr_o  = addr_mem[rd_ptr];
  assign head_wdata_o = wdata_mem[rd_ptr];
  assign head_id_o    = id_mem[rd_ptr];

endmodule

//--- src/addr_router.sv
`timescale 1ns/1ps

module addr_router #(
  parameter int                             RSP_DEPTH  = soc_pkg::RSP_CREDITS,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] SRAM_START = soc_pkg::SRAM_START,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] SRAM_END   = soc_pkg::SRAM_END,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] GPIO_START = soc_pkg::GPIO_START,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] GPIO_END   = soc_pkg::GPIO_END
) (
  input  logic                           clk,
  input  logic                           rst_n_i,

  input  logic                           head_valid_i,
  input  logic                           head_op_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] head_addr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] head_wdata_i,
  input  logic [soc_pkg::ID_WIDTH-1:0]   head_id_i,
  output logic                           pop_o,

  output logic                           tgt_op_o,
  output logic [soc_pkg::ADDR_WIDTH-1:0] tgt_addr_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] tgt_wdata_o,
  output logic                           sram_sel_o,
  output logic                           gpio_sel_o,
  input  logic [soc_pkg::DATA_WIDTH-1:0] sram_rdata_i,
  input  logic                           sram_err_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] gpio_rdata_i,
  input  logic                           gpio_err_i,

  input  logic                           slot_free_i,
  output logic                           push_o,
  output logic [soc_pkg::ID_WIDTH-1:0]   push_id_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] push_rdata_o,
  output logic                           push_err_o
);

  localparam int CNT_W = $clog2(RSP_DEPTH + 1);

  logic                         hit_sram;
  logic                         hit_gpio;
  logic                         issue;
  logic [CNT_W-1:0]             credits;
  logic                         issue_q;
  logic                         sram_q;
  logic                         gpio_q;
  logic [soc_pkg::ID_WIDTH-1:0] id_q;

  assign hit_sram = (head_addr_i >= SRAM_START) && (head_addr_i <= SRAM_END);
  assign hit_gpio = !hit_sram && (head_addr_i >= GPIO_START) && (head_addr_i <= GPIO_END);

  // Issue only with a free slot reserved in the egress FIFO
  assign issue      = head_valid_i && (credits != '0);
  assign pop_o      = issue;
  assign sram_sel_o = issue && hit_sram;
  assign gpio_sel_o = issue && hit_gpio;

  assign tgt_op_o    = head_op_i;
  assign tgt_wdata_o = head_wdata_i;

  // Offset within the matching window
  always_comb begin
    if (hit_sram) begin
      tgt_addr_o = head_addr_i - SRAM_START;
    end else if (hit_gpio) begin
      tgt_addr_o = head_addr_i - GPIO_START;
    end else begin
      tgt_addr_o = head_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      credits <= CNT_W'(RSP_DEPTH);
      issue_q <= 1'b0;
      sram_q  <= 1'b0;
      gpio_q  <= 1'b0;
    end else begin
      credits <= credits - CNT_W'(issue) + CNT_W'(slot_free_i);
      issue_q <= issue;
      sram_q  <= sram_sel_o;
      gpio_q  <= gpio_sel_o;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      id_q <= head_id_i;
    end
  end

  assign push_o    = issue_q;
  assign push_id_o = id_q;

  // Unmapped address gives a decode error with zero data
  always_comb begin
    if (sram_q) begin
      push_rdata_o = sram_rdata_i;
      push_err_o   = sram_err_i;
    end else if (gpio_q) begin
      push_rdata_o = gpio_rdata_i;
      push_err_o   = gpio_err_i;
    end else begin
      push_rdata_o = '0;
      push_err_o   = 1'b1;
    end
  end

endmodule

//--- src/sram_target.sv
`timescale 1ns/1ps

module sram_target #(
  parameter int SRAM_WORDS = 1024
) (
  input  logic                           clk,
  input  logic                           sel_i,
  input  logic                           op_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                           err_o
);

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  logic [soc_pkg::DATA_WIDTH-1:0] mem [SRAM_WORDS];
  logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [IDX_W-1:0]               idx;

  // Word index, byte offset bits dropped
  assign idx = addr_i[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (sel_i) begin
      if (op_i == soc_pkg::OP_READ) begin
        rdata_q <= mem[idx];
      end else begin
        mem[idx] <= wdata_i;
        rdata_q  <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

  // Address already bounded by the router window
  assign err_o = 1'b0;

endmodule

//--- src/gpio_target.sv
`timescale 1ns/1ps

module gpio_target (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic                           sel_i,
  input  logic                           op_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] wdata_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] gpio_in_i,
  output logic [soc_pkg::DATA_WIDTH-1:0] gpio_out_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] gpio_dir_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                           err_o
);

  logic [soc_pkg::DATA_WIDTH-1:0] out_q;
  logic [soc_pkg::DATA_WIDTH-1:0] dir_q;
  logic [soc_pkg::DATA_WIDTH-1:0] in_q;
  logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [soc_pkg::DATA_WIDTH-1:0] reg_mux;
  logic                           err_q;
  logic                           is_out;
  logic                           is_dir;
  logic                           is_in;
  logic                           is_wr;

  assign is_out = (addr_i == soc_pkg::GPIO_OUT_OFS);
  assign is_dir = (addr_i == soc_pkg::GPIO_DIR_OFS);
  assign is_in  = (addr_i == soc_pkg::GPIO_IN_OFS);
  assign is_wr  = (op_i == soc_pkg::OP_WRITE);

  always_comb begin
    reg_mux = '0;
    if (is_out) reg_mux = out_q;
    if (is_dir) reg_mux = dir_q;
    if (is_in)  reg_mux = in_q;
  end

  // Pad input sampled into the clock domain
  always_ff @(posedge clk) begin
    in_q <= gpio_in_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_q <= '0;
      dir_q <= '0;
      err_q <= 1'b0;
    end else begin
      if (sel_i && is_wr && is_out) begin
        out_q <= wdata_i;
      end
      if (sel_i && is_wr && is_dir) begin
        dir_q <= wdata_i;
      end
      // Write to the input register is silently dropped
      err_q <= sel_i && !(is_out || is_dir || is_in);
    end
  end

  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_q <= is_wr ? '0 : reg_mux;
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign rdata_o    = rdata_q;
  assign err_o      = err_q;

endmodule

//--- src/rsp_egress.sv
`timescale 1ns/1ps

module rsp_egress #(
  parameter int RSP_DEPTH = soc_pkg::RSP_CREDITS
) (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic                           push_i,
  input  logic [soc_pkg::ID_WIDTH-1:0]   push_id_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] push_rdata_i,
  input  logic                           push_err_i,
  input  logic                           rsp_credit_i,
  output logic                           slot_free_o,
  output logic                           rsp_valid_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                           rsp_err_o,
  output logic [soc_pkg::ID_WIDTH-1:0]   rsp_id_o
);

  localparam int PTR_W  = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
  localparam int CNT_W  = $clog2(RSP_DEPTH + 1);
  localparam int CRED_W = $clog2(soc_pkg::RSP_CREDITS + 1);

  logic [soc_pkg::ID_WIDTH-1:0]   id_mem    [RSP_DEPTH];
  logic [soc_pkg::DATA_WIDTH-1:0] rdata_mem [RSP_DEPTH];
  logic                           err_mem   [RSP_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] host_credits;
  logic              push;
  logic              send;

  // Router credits keep this FIFO from overflowing
  assign push = push_i && (count != CNT_W'(RSP_DEPTH));
  assign send = (count != '0) && (host_credits != '0);

  // Leaving entry frees a router credit
  assign slot_free_o = send;

  always_ff @(posedge clk) begin
    if (push) begin
      id_mem[wr_ptr]    <= push_id_i;
      rdata_mem[wr_ptr] <= push_rdata_i;
      err_mem[wr_ptr]   <= push_err_i;
    end
    if (send) begin
      rsp_rdata_o <= rdata_mem[rd_ptr];
      rsp_id_o    <= id_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      host_credits <= CRED_W'(soc_pkg::RSP_CREDITS);
      rsp_valid_o  <= 1'b0;
      rsp_err_o    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count        <= count + CNT_W'(push) - CNT_W'(send);
      host_credits <= host_credits - CRED_W'(send) + CRED_W'(rsp_credit_i);
      rsp_valid_o  <= send;
      rsp_err_o    <= send && err_mem[rd_ptr];
    end
  end

endmodule

//--- src/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int                             REQ_DEPTH  = soc_pkg::REQ_CREDITS,
  parameter int                             RSP_DEPTH  = soc_pkg::RSP_CREDITS,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] SRAM_START = soc_pkg::SRAM_START,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] SRAM_END   = soc_pkg::SRAM_END,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] GPIO_START = soc_pkg::GPIO_START,
  parameter logic [soc_pkg::ADDR_WIDTH-1:0] GPIO_END   = soc_pkg::GPIO_END,
  parameter int                             SRAM_WORDS = int'((SRAM_END - SRAM_START + 1) / 4)
) (
  input  logic                           clk,
  input  logic                           rst_n_i,

  // Host request port
  input  logic                           req_valid_i,
  input  logic                           req_op_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] req_addr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] req_wdata_i,
  input  logic [soc_pkg::ID_WIDTH-1:0]   req_id_i,
  output logic                           req_credit_o,

  // Host response port
  output logic                           rsp_valid_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                           rsp_err_o,
  output logic [soc_pkg::ID_WIDTH-1:0]   rsp_id_o,
  input  logic                           rsp_credit_i,

  // GPIO pads
  input  logic [soc_pkg::DATA_WIDTH-1:0] gpio_in_i,
  output logic [soc_pkg::DATA_WIDTH-1:0] gpio_out_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] gpio_dir_o
);

  logic                           head_valid;
  logic                           head_op;
  logic [soc_pkg::ADDR_WIDTH-1:0] head_addr;
  logic [soc_pkg::DATA_WIDTH-1:0] head_wdata;
  logic [soc_pkg::ID_WIDTH-1:0]   head_id;
  logic                           pop;

  logic                           tgt_op;
  logic [soc_pkg::ADDR_WIDTH-1:0] tgt_addr;
  logic [soc_pkg::DATA_WIDTH-1:0] tgt_wdata;
  logic                           sram_sel;
  logic                           gpio_sel;
  logic [soc_pkg::DATA_WIDTH-1:0] sram_rdata;
  logic                           sram_err;
  logic [soc_pkg::DATA_WIDTH-1:0] gpio_rdata;
  logic                           gpio_err;

  logic                           push;
  logic [soc_pkg::ID_WIDTH-1:0]   push_id;
  logic [soc_pkg::DATA_WIDTH-1:0] push_rdata;
  logic                           push_err;
  logic                           slot_free;

  req_ingress #(.REQ_DEPTH(REQ_DEPTH)) u_req_ingress (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .req_valid_i  ( req_valid_i  ),
    .req_op_i     ( req_op_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_id_i     ( req_id_i     ),
    .pop_i        ( pop          ),
    .head_valid_o ( head_valid   ),
    .head_op_o    ( head_op      ),
    .head_addr_o  ( head_addr    ),
    .head_wdata_o ( head_wdata   ),
    .head_id_o    ( head_id      ),
    .req_credit_o ( req_credit_o )
  );

  addr_router #(
    .RSP_DEPTH  ( RSP_DEPTH  ),
    .SRAM_START ( SRAM_START ),
    .SRAM_END   ( SRAM_END   ),
    .GPIO_START ( GPIO_START ),
    .GPIO_END   ( GPIO_END   )
  ) u_addr_router (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n_i    ),
    .head_valid_i ( head_valid ),
    .head_op_i    ( head_op    ),
    .head_addr_i  ( head_addr  ),
    .head_wdata_i ( head_wdata ),
    .head_id_i    ( head_id    ),
    .pop_o        ( pop        ),
    .tgt_op_o     ( tgt_op     ),
    .tgt_addr_o   ( tgt_addr   ),
    .tgt_wdata_o  ( tgt_wdata  ),
    .sram_sel_o   ( sram_sel   ),
    .gpio_sel_o   ( gpio_sel   ),
    .sram_rdata_i ( sram_rdata ),
    .sram_err_i   ( sram_err   ),
    .gpio_rdata_i ( gpio_rdata ),
    .gpio_err_i   ( gpio_err   ),
    .slot_free_i  ( slot_free  ),
    .push_o       ( push       ),
    .push_id_o    ( push_id    ),
    .push_rdata_o ( push_rdata ),
    .push_err_o   ( push_err   )
  );

  sram_target #(.SRAM_WORDS(SRAM_WORDS)) u_sram_target (
    .clk     ( clk        ),
    .sel_i   ( sram_sel   ),
    .op_i    ( tgt_op     ),
    .addr_i  ( tgt_addr   ),
    .wdata_i ( tgt_wdata  ),
    .rdata_o ( sram_rdata ),
    .err_o   ( sram_err   )
  );

  gpio_target u_gpio_target (
    .clk        ( clk        ),
    .rst_n_i    ( rst_n_i    ),
    .sel_i      ( gpio_sel   ),
    .op_i       ( tgt_op     ),
    .addr_i     ( tgt_addr   ),
    .wdata_i    ( tgt_wdata  ),
    .gpio_in_i  ( gpio_in_i  ),
    .gpio_out_o ( gpio_out_o ),
    .gpio_dir_o ( gpio_dir_o ),
    .rdata_o    ( gpio_rdata ),
    .err_o      ( gpio_err   )
  );

  rsp_egress #(.RSP_DEPTH(RSP_DEPTH)) u_rsp_egress (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .push_i       ( push         ),
    .push_id_i    ( push_id      ),
    .push_rdata_i ( push_rdata   ),
    .push_err_i   ( push_err     ),
    .rsp_credit_i ( rsp_credit_i ),
    .slot_free_o  ( slot_free    ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_rdata_o  ( rsp_rdata_o  ),
    .rsp_err_o    ( rsp_err_o    ),
    .rsp_id_o     ( rsp_id_o     )
  );

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  // Free running, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

//--- tb/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

  localparam int CLK_PERIOD_NS = 40;
  localparam int RESET_CYCLES  = 5;
  localparam int STALL_CYCLES  = 20;
  localparam int SEED          = 43871;

  localparam logic [31:0] OUT_ADDR = soc_pkg::GPIO_START + soc_pkg::GPIO_OUT_OFS;
  localparam logic [31:0] DIR_ADDR = soc_pkg::GPIO_START + soc_pkg::GPIO_DIR_OFS;
  localparam logic [31:0] IN_ADDR  = soc_pkg::GPIO_START + soc_pkg::GPIO_IN_OFS;

  typedef logic [soc_pkg::ID_WIDTH-1:0] id_t;

  typedef struct packed {
    logic                           op;
    logic [soc_pkg::ADDR_WIDTH-1:0] addr;
    logic [soc_pkg::DATA_WIDTH-1:0] wdata;
    id_t                            id;
    logic [soc_pkg::DATA_WIDTH-1:0] gpio_in;
    logic [soc_pkg::DATA_WIDTH-1:0] exp_rdata;
    logic                           exp_err;
  } vector_t;

  logic                           clk;
  logic                           rst_n;
  logic                           req_valid;
  logic                           req_op;
  logic [soc_pkg::ADDR_WIDTH-1:0] req_addr;
  logic [soc_pkg::DATA_WIDTH-1:0] req_wdata;
  id_t                            req_id;
  logic                           req_credit;
  logic                           rsp_valid;
  logic [soc_pkg::DATA_WIDTH-1:0] rsp_rdata;
  logic                           rsp_err;
  id_t                            rsp_id;
  logic                           rsp_credit;
  logic [soc_pkg::DATA_WIDTH-1:0] gpio_in;
  logic [soc_pkg::DATA_WIDTH-1:0] gpio_out;
  logic [soc_pkg::DATA_WIDTH-1:0] gpio_dir;

  vector_t     vectors[$];
  int          sent_q[$];
  int          group_last[5];
  logic [31:0] table_gpio_in;
  logic        hold_credits;
  int          sent = 0;
  int          credit_pulses = 0;
  int          rsp_count = 0;
  int          credits_returned = 0;
  int          mon_errors = 0;
  int          main_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk_gen (
    .clk_o ( clk )
  );

  soc_top u_soc_top (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n      ),
    .req_valid_i  ( req_valid  ),
    .req_op_i     ( req_op     ),
    .req_addr_i   ( req_addr   ),
    .req_wdata_i  ( req_wdata  ),
    .req_id_i     ( req_id     ),
    .req_credit_o ( req_credit ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_rdata_o  ( rsp_rdata  ),
    .rsp_err_o    ( rsp_err    ),
    .rsp_id_o     ( rsp_id     ),
    .rsp_credit_i ( rsp_credit ),
    .gpio_in_i    ( gpio_in    ),
    .gpio_out_o   ( gpio_out   ),
    .gpio_dir_o   ( gpio_dir   )
  );

  function automatic int check_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  function automatic int host_credits();
    return soc_pkg::REQ_CREDITS + credit_pulses - sent;
  endfunction

  task automatic add_vector(input logic op, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_rdata, input logic exp_err);
    vector_t v;
    v.op        = op;
    v.addr      = addr;
    v.wdata     = wdata;
    v.id        = id_t'(vectors.size() % 4);
    v.gpio_in   = table_gpio_in;
    v.exp_rdata = exp_rdata;
    v.exp_err   = exp_err;
    vectors.push_back(v);
  endtask

  task automatic build_table();
    logic [31:0] a;
    table_gpio_in = 32'h0;
    // SRAM write then read back, out of address order
    add_vector(soc_pkg::OP_WRITE, 32'h0000_0000, 32'h1111_0000, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_WRITE, 32'h0000_0004, 32'h2222_0004, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_WRITE, 32'h0000_07F0, 32'h3333_07F0, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_WRITE, 32'h0000_0FFC, 32'h4444_0FFC, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_READ,  32'h0000_0000, 32'h0, 32'h1111_0000, 1'b0);
    add_vector(soc_pkg::OP_READ,  32'h0000_0FFC, 32'h0, 32'h4444_0FFC, 1'b0);
    add_vector(soc_pkg::OP_READ,  32'h0000_0004, 32'h0, 32'h2222_0004, 1'b0);
    add_vector(soc_pkg::OP_READ,  32'h0000_07F0, 32'h0, 32'h3333_07F0, 1'b0);
    group_last[0] = vectors.size() - 1;
    add_vector(soc_pkg::OP_WRITE, OUT_ADDR, 32'hA5A5_0F0F, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_WRITE, DIR_ADDR, 32'h0000_FFFF, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_READ,  OUT_ADDR, 32'h0, 32'hA5A5_0F0F, 1'b0);
    add_vector(soc_pkg::OP_READ,  DIR_ADDR, 32'h0, 32'h0000_FFFF, 1'b0);
    group_last[1] = vectors.size() - 1;
    table_gpio_in = 32'h1234_5678;
    add_vector(soc_pkg::OP_READ, IN_ADDR, 32'h0, 32'h1234_5678, 1'b0);
    table_gpio_in = 32'hCAFE_0001;
    add_vector(soc_pkg::OP_READ, IN_ADDR, 32'h0, 32'hCAFE_0001, 1'b0);
    group_last[2] = vectors.size() - 1;
    // Unmapped addresses and bad GPIO offsets
    add_vector(soc_pkg::OP_READ,  32'h2000_0000, 32'h0, 32'h0, 1'b1);
    add_vector(soc_pkg::OP_WRITE, 32'h0000_1000, 32'hDEAD_BEEF, 32'h0, 1'b1);
    add_vector(soc_pkg::OP_READ,  soc_pkg::GPIO_START + 32'hC, 32'h0, 32'h0, 1'b1);
    add_vector(soc_pkg::OP_WRITE, soc_pkg::GPIO_START + 32'h10, 32'h1, 32'h0, 1'b1);
    add_vector(soc_pkg::OP_WRITE, IN_ADDR, 32'hFFFF_FFFF, 32'h0, 1'b0);
    add_vector(soc_pkg::OP_READ,  IN_ADDR, 32'h0, 32'hCAFE_0001, 1'b0);
    add_vector(soc_pkg::OP_READ,  32'h0000_0004, 32'h0, 32'h2222_0004, 1'b0);
    group_last[3] = vectors.size() - 1;
    // Enough traffic to fill both FIFOs and stall the host
    for (int i = 0; i < 7; i++) begin
      a = 32'h0000_0100 + 32'(i * 4);
      add_vector(soc_pkg::OP_WRITE, a, 32'hB000_0000 + (a << 8) + a, 32'h0, 1'b0);
    end
    for (int i = 0; i < 7; i++) begin
      a = 32'h0000_0100 + 32'(i * 4);
      add_vector(soc_pkg::OP_READ, a, 32'h0, 32'hB000_0000 + (a << 8) + a, 1'b0);
    end
    group_last[4] = vectors.size() - 1;
  endtask

  task automatic wait_idle();
    while (rsp_count != sent) @(posedge clk);
  endtask

  task automatic send_range(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      @(posedge clk);
      // New pad value only with the fabric idle, then let it settle
      if (vectors[i].gpio_in != gpio_in) begin
        req_valid <= 1'b0;
        wait_idle();
        gpio_in <= vectors[i].gpio_in;
        repeat (3) @(posedge clk);
      end
      while (host_credits() == 0) begin
        req_valid <= 1'b0;
        @(posedge clk);
      end
      req_valid <= 1'b1;
      req_op    <= vectors[i].op;
      req_addr  <= vectors[i].addr;
      req_wdata <= vectors[i].wdata;
      req_id    <= vectors[i].id;
      sent_q.push_back(i);
      sent++;
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (mon_errors + main_errors == err_before) begin
      $display("test %s: pass", name);
      tests_passed++;
    end else begin
      $display("test %s: FAIL, %0d errors", name, mon_errors + main_errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic run_group(input int first, input int last, input string name);
    int err_before;
    err_before = mon_errors + main_errors;
    send_range(first, last);
    wait_idle();
    report_test(name, err_before);
  endtask

  task automatic run_backpressure(input int first, input int last, input string name);
    int err_before;
    int rsp_mark;
    int pulse_mark;
    int pulse_seen;
    err_before = mon_errors + main_errors;
    wait_idle();
    while (credits_returned != rsp_count) @(posedge clk);
    repeat (2) @(posedge clk);
    rsp_mark     = rsp_count;
    pulse_mark   = credit_pulses;
    hold_credits = 1'b1;
    fork
      send_range(first, last);
      begin
        while (rsp_count - rsp_mark < soc_pkg::RSP_CREDITS) @(posedge clk);
        repeat (STALL_CYCLES) @(posedge clk);
        pulse_seen = credit_pulses;
        repeat (STALL_CYCLES) @(posedge clk);
        if (rsp_count - rsp_mark != soc_pkg::RSP_CREDITS) begin
          $display("ERROR t=%0t rsp_valid_o pulses: got %0d expected %0d", $time,
                   rsp_count - rsp_mark, soc_pkg::RSP_CREDITS);
          main_errors++;
        end
        if (credit_pulses - pulse_mark > soc_pkg::RSP_CREDITS + soc_pkg::REQ_CREDITS) begin
          $display("ERROR t=%0t req_credit_o pulses: got %0d expected at most %0d", $time,
                   credit_pulses - pulse_mark, soc_pkg::RSP_CREDITS + soc_pkg::REQ_CREDITS);
          main_errors++;
        end
        if (credit_pulses != pulse_seen) begin
          $display("Request credits kept coming back while the response path was full");
          main_errors++;
        end
        if (host_credits() != 0) begin
          $display("Host was never stalled although response credits were withheld");
          main_errors++;
        end
        hold_credits = 1'b0;
      end
    join
    wait_idle();
    report_test(name, err_before);
  endtask

  task automatic watchdog();
    int limit_ns;
    limit_ns = vectors.size() * 60 * CLK_PERIOD_NS;
    #(limit_ns);
    $display("Timeout: run did not complete within %0d ns", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Host side monitor, sampled mid cycle
  always @(negedge clk) begin : monitor
    vector_t v;
    if (rst_n) begin
      if (req_credit) begin
        credit_pulses++;
      end
      if (rsp_valid) begin
        if (rsp_count >= sent_q.size()) begin
          $display("ERROR t=%0t response arrived with no request outstanding", $time);
          mon_errors++;
        end else begin
          v = vectors[sent_q[rsp_count]];
          mon_errors += check_value("rsp_id_o", 32'(rsp_id), 32'(v.id));
          mon_errors += check_value("rsp_rdata_o", rsp_rdata, v.exp_rdata);
          mon_errors += check_value("rsp_err_o", 32'(rsp_err), 32'(v.exp_err));
          if (v.op == soc_pkg::OP_WRITE && !v.exp_err && v.addr == OUT_ADDR) begin
            mon_errors += check_value("gpio_out_o", gpio_out, v.wdata);
          end
          if (v.op == soc_pkg::OP_WRITE && !v.exp_err && v.addr == DIR_ADDR) begin
            mon_errors += check_value("gpio_dir_o", gpio_dir, v.wdata);
          end
        end
        rsp_count++;
      end
    end
  end

  // Response credits go back after a random delay
  initial begin : credit_return
    int delay;
    void'($urandom(SEED));
    rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      if (!hold_credits && rsp_count > credits_returned) begin
        delay = int'($urandom % 6);
        repeat (delay) @(posedge clk);
        rsp_credit <= 1'b1;
        credits_returned++;
        @(posedge clk);
        rsp_credit <= 1'b0;
      end
    end
  end

  initial begin : main
    int err_before;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_op       = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    req_id       = '0;
    gpio_in      = '0;
    hold_credits = 1'b0;
    build_table();
    fork
      watchdog();
    join_none
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    err_before = mon_errors + main_errors;
    main_errors += check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);
    main_errors += check_value("req_credit_o", 32'(req_credit), 32'h0);
    main_errors += check_value("gpio_out_o", gpio_out, 32'h0);
    main_errors += check_value("gpio_dir_o", gpio_dir, 32'h0);
    report_test("outputs idle after reset", err_before);
    run_group(0, group_last[0], "sram write and read back");
    run_group(group_last[0] + 1, group_last[1], "gpio out and dir registers");
    run_group(group_last[1] + 1, group_last[2], "gpio input sampling");
    run_group(group_last[2] + 1, group_last[3], "decode and offset errors");
    run_backpressure(group_last[3] + 1, group_last[4], "flow control under back-pressure");
    err_before = mon_errors + main_errors;
    main_errors += check_value("req_credit_o pulses", 32'(credit_pulses), 32'(sent));
    report_test("request credit balance", err_before);
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
             mon_errors + main_errors);
    if (tests_failed == 0 && mon_errors + main_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
src/soc_pkg.sv
src/req_ingress.sv
src/addr_router.sv
src/sram_target.sv
src/gpio_target.sv
src/rsp_egress.sv
src/soc_top.sv
tb/clk_gen.sv
tb/soc_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := soc_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
